// File: source/cpu_pkg.sv
package cpu_pkg;
	typedef logic [31:0] data_t;
	typedef logic [9:0] pc_t; // IMEM word address
	typedef logic [7:0] dmem_addr_t; // DMEM word address
	typedef logic [4:0] reg_idx_t;
	typedef logic [3:0] uart_addr_t;

	localparam int IMEM_DEPTH = 1024;
	localparam int DMEM_DEPTH = 256;
	localparam reg_idx_t LINK_REG = 5'd31;

	// UART-lite register map
	localparam uart_addr_t UART_RX_FIFO = 4'h0;
	localparam uart_addr_t UART_TX_FIFO = 4'h4;
	localparam uart_addr_t UART_STAT = 4'h8;
	localparam uart_addr_t UART_CTRL = 4'hC;
	localparam int STAT_RX_VALID = 0; // Status bits
	localparam int STAT_TX_FULL = 3;
	localparam logic [1:0] AXI_OKAY = 2'b00;

	typedef enum logic [2:0] {
		GRP_IMM, GRP_REG, GRP_LOGIC, GRP_MEM, GRP_JUMP, GRP_BRANCH, GRP_IO
	} op_group_e;

	// Sub-operations in bits 28:26
	localparam logic [2:0] SUB_ADD = 3'd0; // GRP_IMM and GRP_REG
	localparam logic [2:0] SUB_SUB = 3'd1;
	localparam logic [2:0] SUB_AND = 3'd0; // GRP_LOGIC
	localparam logic [2:0] SUB_OR = 3'd1;
	localparam logic [2:0] SUB_SRA = 3'd2;
	localparam logic [2:0] SUB_SLA = 3'd3;
	localparam logic [2:0] SUB_LD = 3'd0; // GRP_MEM
	localparam logic [2:0] SUB_ST = 3'd1;
	localparam logic [2:0] SUB_LI = 3'd2;
	localparam logic [2:0] SUB_LIS = 3'd3;
	localparam logic [2:0] SUB_J = 3'd0; // GRP_JUMP
	localparam logic [2:0] SUB_JR = 3'd1;
	localparam logic [2:0] SUB_BL = 3'd2;
	localparam logic [2:0] SUB_BLR = 3'd3;
	localparam logic [2:0] SUB_BEQ = 3'd0; // GRP_BRANCH
	localparam logic [2:0] SUB_BLE = 3'd1;
	localparam logic [2:0] SUB_CMP = 3'd2;
	localparam logic [2:0] SUB_BLT = 3'd4;
	// GRP_IO sub-ops 1xx output the byte picked by bits 27:26

	typedef enum logic [2:0] {ADD, SUB, AND, OR, SRA, SLA} alu_op_e;

	typedef enum logic [2:0] {
		IDLE, FETCH, DECODE, EXEC, MEM, OUT_POLL, OUT_WRITE
	} core_state_e;

	typedef enum logic [1:0] {POLL, READ, WRITE, DONE} loader_state_e;
endpackage

// File: source/axil_if.sv
`timescale 1ns/10ps

interface axil_if;
	cpu_pkg::uart_addr_t araddr;
	logic arvalid;
	logic arready;
	cpu_pkg::data_t rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	cpu_pkg::uart_addr_t awaddr;
	logic awvalid;
	logic awready;
	cpu_pkg::data_t wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;

	modport master (
		output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
		input arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
	);
	modport slave (
		input araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
		output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
	);
endinterface

// File: source/cpu_alu.sv
`timescale 1ns/10ps

module cpu_alu (
	input cpu_pkg::alu_op_e op,
	input cpu_pkg::data_t a,
	input cpu_pkg::data_t b,
	output cpu_pkg::data_t y
);
	always_comb begin
		case (op)
			cpu_pkg::SUB: y = a - b;
			cpu_pkg::AND: y = a & b;
			cpu_pkg::OR: y = a | b;
			cpu_pkg::SRA: y = $signed(a) >>> b[4:0]; // Sign fill
			cpu_pkg::SLA: y = a << b[4:0];
			default: y = a + b;
		endcase
	end
endmodule

// File: source/inst_ram.sv
`timescale 1ns/10ps

module inst_ram (
	input logic clk,
	input logic we,
	input cpu_pkg::pc_t waddr,
	input cpu_pkg::data_t wdata,
	input cpu_pkg::pc_t raddr,
	output cpu_pkg::data_t rdata
);
	cpu_pkg::data_t mem [cpu_pkg::IMEM_DEPTH];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr]; // One cycle read
	end
endmodule

// File: source/uart_arbiter.sv
`timescale 1ns/10ps

module uart_arbiter (
	input logic clk,
	input logic rstn,
	axil_if.slave ld_bus,
	axil_if.slave core_bus,
	axil_if.master uart_bus
);
	logic busy; // Transaction open
	logic own_core;
	logic ld_req;
	logic core_req;
	logic sel_core;
	logic ld_gnt;
	logic core_gnt;

	assign ld_req = ld_bus.arvalid || ld_bus.awvalid;
	assign core_req = core_bus.arvalid || core_bus.awvalid;
	// Loader wins ties when idle
	assign sel_core = busy ? own_core : !ld_req;
	assign ld_gnt = !sel_core && (busy || ld_req);
	assign core_gnt = sel_core && (busy || core_req);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			busy <= 1'b0;
			own_core <= 1'b0;
		end else if (!busy) begin
			if (ld_req || core_req) begin
				busy <= 1'b1;
				own_core <= sel_core;
			end
		end else if ((uart_bus.rvalid && uart_bus.rready) ||
				(uart_bus.bvalid && uart_bus.bready)) begin
			busy <= 1'b0;
		end
	end

	assign uart_bus.araddr = sel_core ? core_bus.araddr : ld_bus.araddr;
	assign uart_bus.arvalid = sel_core ? core_bus.arvalid : ld_bus.arvalid;
	assign uart_bus.rready = sel_core ? core_bus.rready : ld_bus.rready;
	assign uart_bus.awaddr = sel_core ? core_bus.awaddr : ld_bus.awaddr;
	assign uart_bus.awvalid = sel_core ? core_bus.awvalid : ld_bus.awvalid;
	assign uart_bus.wdata = sel_core ? core_bus.wdata : ld_bus.wdata;
	assign uart_bus.wstrb = sel_core ? core_bus.wstrb : ld_bus.wstrb;
	assign uart_bus.wvalid = sel_core ? core_bus.wvalid : ld_bus.wvalid;
	assign uart_bus.bready = sel_core ? core_bus.bready : ld_bus.bready;

	// Handshakes only reach the owner
	assign ld_bus.arready = uart_bus.arready && ld_gnt;
	assign ld_bus.rvalid = uart_bus.rvalid && ld_gnt;
	assign ld_bus.awready = uart_bus.awready && ld_gnt;
	assign ld_bus.wready = uart_bus.wready && ld_gnt;
	assign ld_bus.bvalid = uart_bus.bvalid && ld_gnt;
	assign core_bus.arready = uart_bus.arready && core_gnt;
	assign core_bus.rvalid = uart_bus.rvalid && core_gnt;
	assign core_bus.awready = uart_bus.awready && core_gnt;
	assign core_bus.wready = uart_bus.wready && core_gnt;
	assign core_bus.bvalid = uart_bus.bvalid && core_gnt;

	assign ld_bus.rdata = uart_bus.rdata;
	assign ld_bus.rresp = uart_bus.rresp;
	assign ld_bus.bresp = uart_bus.bresp;
	assign core_bus.rdata = uart_bus.rdata;
	assign core_bus.rresp = uart_bus.rresp;
	assign core_bus.bresp = uart_bus.bresp;
endmodule

// File: source/boot_loader.sv
`timescale 1ns/10ps

module boot_loader (
	input logic clk,
	input logic rstn,
	input logic load_start,
	input logic run_start,
	axil_if.master bus,
	output logic imem_we,
	output cpu_pkg::pc_t imem_waddr,
	output cpu_pkg::data_t imem_wdata
);
	cpu_pkg::loader_state_e state;
	cpu_pkg::pc_t wptr;
	cpu_pkg::data_t word;
	logic [1:0] cnt; // Bytes held in word
	logic rd_open;
	logic stop; // run_start seen mid transaction

	assign imem_we = (state == cpu_pkg::WRITE);
	assign imem_waddr = wptr;
	assign imem_wdata = word;

	// No writes from the loader
	assign bus.awaddr = '0;
	assign bus.awvalid = 1'b0;
	assign bus.wdata = '0;
	assign bus.wstrb = '0;
	assign bus.wvalid = 1'b0;
	assign bus.bready = 1'b0;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= cpu_pkg::DONE; // Idle until load_start
			wptr <= '0;
			cnt <= '0;
			rd_open <= 1'b0;
			stop <= 1'b0;
			bus.arvalid <= 1'b0;
			bus.rready <= 1'b0;
		end else begin
			if (bus.arready)
				bus.arvalid <= 1'b0;
			if (run_start)
				stop <= 1'b1;
			case (state)
				cpu_pkg::DONE: if (load_start && !run_start) begin
					stop <= 1'b0;
					wptr <= '0;
					cnt <= '0;
					state <= cpu_pkg::POLL;
				end
				cpu_pkg::WRITE: begin
					wptr <= wptr + 1'b1;
					state <= cpu_pkg::POLL;
				end
				default: begin // POLL and READ
					if (!rd_open) begin
						if (stop || run_start) begin
							state <= cpu_pkg::DONE;
						end else begin
							bus.arvalid <= 1'b1;
							bus.araddr <= (state == cpu_pkg::READ) ?
								cpu_pkg::UART_RX_FIFO : cpu_pkg::UART_STAT;
							bus.rready <= 1'b1;
							rd_open <= 1'b1;
						end
					end else if (bus.rvalid) begin
						bus.rready <= 1'b0;
						rd_open <= 1'b0;
						if (state == cpu_pkg::POLL) begin
							if (bus.rresp == cpu_pkg::AXI_OKAY &&
									bus.rdata[cpu_pkg::STAT_RX_VALID])
								state <= cpu_pkg::READ;
						end else begin
							state <= cpu_pkg::POLL;
							if (bus.rresp == cpu_pkg::AXI_OKAY) begin
								word <= {bus.rdata[7:0], word[31:8]}; // First byte ends low
								cnt <= cnt + 1'b1;
								if (cnt == 2'd3)
									state <= cpu_pkg::WRITE;
							end
						end
					end
				end
			endcase
		end
	end
endmodule

// File: source/cpu_core.sv
`timescale 1ns/10ps

module cpu_core (
	input logic clk,
	input logic rstn,
	input logic run_start,
	output cpu_pkg::pc_t imem_raddr,
	input cpu_pkg::data_t imem_rdata,
	axil_if.master bus
);
	cpu_pkg::core_state_e state;
	cpu_pkg::pc_t pc;
	cpu_pkg::pc_t pc_inc;
	cpu_pkg::pc_t li_pc;
	cpu_pkg::data_t ir;
	cpu_pkg::data_t srca;
	cpu_pkg::data_t srcb;
	cpu_pkg::data_t srcs; // rt operand
	cpu_pkg::data_t alu_b;
	cpu_pkg::data_t alu_y;
	cpu_pkg::data_t rf_wd;
	cpu_pkg::alu_op_e alu_op;
	cpu_pkg::op_group_e grp;
	cpu_pkg::reg_idx_t rt;
	cpu_pkg::reg_idx_t ra;
	cpu_pkg::reg_idx_t rb;
	cpu_pkg::reg_idx_t rf_wa;
	cpu_pkg::dmem_addr_t dm_addr;
	logic [2:0] sub;
	logic [15:0] si;
	logic [7:0] out_byte;
	logic fetch_ph;
	logic rd_open;
	logic eq;
	logic less;
	logic rf_we;
	logic dm_we;

	cpu_pkg::data_t rf [32];
	cpu_pkg::data_t dmem [cpu_pkg::DMEM_DEPTH];

	assign grp = cpu_pkg::op_group_e'(ir[31:29]);
	assign sub = ir[28:26];
	assign rt = ir[25:21];
	assign ra = ir[20:16];
	assign rb = ir[15:11];
	assign si = ir[15:0];
	assign li_pc = ir[9:0]; // Only the IMEM part of li
	assign pc_inc = pc + 1'b1;
	assign dm_addr = alu_y[7:0];
	assign imem_raddr = pc;

	// Output path polls status and writes TX only
	assign bus.araddr = cpu_pkg::UART_STAT;
	assign bus.awaddr = cpu_pkg::UART_TX_FIFO;
	assign bus.wdata = {24'd0, out_byte};
	assign bus.wstrb = 4'b0001;

	cpu_alu i_alu (.op(alu_op), .a(srca), .b(alu_b), .y(alu_y));

	always_comb begin
		alu_op = cpu_pkg::ADD; // Also the load/store address
		alu_b = {16'd0, si};
		case (grp)
			cpu_pkg::GRP_IMM: if (sub == cpu_pkg::SUB_SUB) alu_op = cpu_pkg::SUB;
			cpu_pkg::GRP_REG: begin
				alu_b = srcb;
				if (sub == cpu_pkg::SUB_SUB)
					alu_op = cpu_pkg::SUB;
			end
			cpu_pkg::GRP_LOGIC: begin
				case (sub)
					cpu_pkg::SUB_AND: alu_op = cpu_pkg::AND;
					cpu_pkg::SUB_OR: alu_op = cpu_pkg::OR;
					cpu_pkg::SUB_SRA: alu_op = cpu_pkg::SRA;
					default: alu_op = cpu_pkg::SLA;
				endcase
				if (sub == cpu_pkg::SUB_AND || sub == cpu_pkg::SUB_OR)
					alu_b = srcb;
			end
			default: ;
		endcase
	end

	// Write-back at the end of EXEC or MEM
	always_comb begin
		rf_we = 1'b0;
		rf_wa = rt;
		rf_wd = alu_y;
		dm_we = 1'b0;
		if (state == cpu_pkg::EXEC) begin
			case (grp)
				cpu_pkg::GRP_IMM, cpu_pkg::GRP_REG:
					rf_we = (sub == cpu_pkg::SUB_ADD) || (sub == cpu_pkg::SUB_SUB);
				cpu_pkg::GRP_LOGIC: rf_we = !sub[2];
				cpu_pkg::GRP_MEM: begin
					rf_we = (sub == cpu_pkg::SUB_LI) || (sub == cpu_pkg::SUB_LIS);
					rf_wd = (sub == cpu_pkg::SUB_LI) ? {16'd0, si} : {si, 16'd0};
				end
				cpu_pkg::GRP_JUMP: if (sub == cpu_pkg::SUB_BL || sub == cpu_pkg::SUB_BLR) begin
					rf_we = 1'b1;
					rf_wa = cpu_pkg::LINK_REG;
					rf_wd = {22'd0, pc_inc};
				end
				default: ;
			endcase
		end else if (state == cpu_pkg::MEM) begin
			rf_we = (sub == cpu_pkg::SUB_LD);
			rf_wd = dmem[dm_addr];
			dm_we = (sub == cpu_pkg::SUB_ST);
		end
	end

	always_ff @(posedge clk) begin
		if (rf_we)
			rf[rf_wa] <= rf_wd;
		if (dm_we)
			dmem[dm_addr] <= srcs;
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= cpu_pkg::IDLE;
			pc <= '0;
			fetch_ph <= 1'b0;
			rd_open <= 1'b0;
			eq <= 1'b0;
			less <= 1'b0;
			bus.arvalid <= 1'b0;
			bus.rready <= 1'b0;
			bus.awvalid <= 1'b0;
			bus.wvalid <= 1'b0;
			bus.bready <= 1'b0;
		end else begin
			if (bus.arready)
				bus.arvalid <= 1'b0;
			if (bus.awready)
				bus.awvalid <= 1'b0;
			if (bus.wready)
				bus.wvalid <= 1'b0;
			case (state)
				cpu_pkg::IDLE: if (run_start) begin
					pc <= '0;
					state <= cpu_pkg::FETCH;
				end
				cpu_pkg::FETCH: begin
					fetch_ph <= !fetch_ph; // Address cycle, then data
					if (fetch_ph) begin
						ir <= imem_rdata;
						state <= cpu_pkg::DECODE;
					end
				end
				cpu_pkg::DECODE: begin
					srca <= rf[ra];
					srcb <= rf[rb];
					srcs <= rf[rt];
					state <= cpu_pkg::EXEC;
				end
				cpu_pkg::EXEC: begin
					pc <= pc_inc;
					state <= cpu_pkg::FETCH;
					case (grp)
						cpu_pkg::GRP_MEM:
							if (sub == cpu_pkg::SUB_LD || sub == cpu_pkg::SUB_ST)
								state <= cpu_pkg::MEM;
						cpu_pkg::GRP_JUMP: begin
							if (sub == cpu_pkg::SUB_J || sub == cpu_pkg::SUB_BL)
								pc <= li_pc;
							else if (sub == cpu_pkg::SUB_JR || sub == cpu_pkg::SUB_BLR)
								pc <= srcs[9:0];
						end
						cpu_pkg::GRP_BRANCH: begin
							case (sub)
								cpu_pkg::SUB_BEQ: if (eq) pc <= li_pc;
								cpu_pkg::SUB_BLE: if (eq || less) pc <= li_pc;
								cpu_pkg::SUB_BLT: if (less) pc <= li_pc;
								cpu_pkg::SUB_CMP: begin // ra against rb, signed
									eq <= (srca == srcb);
									less <= ($signed(srca) < $signed(srcb));
								end
								default: ;
							endcase
						end
						cpu_pkg::GRP_IO: if (sub[2]) begin
							out_byte <= srcs[{sub[1:0], 3'b000} +: 8];
							state <= cpu_pkg::OUT_POLL;
						end
						default: ;
					endcase
				end
				cpu_pkg::MEM: state <= cpu_pkg::FETCH;
				cpu_pkg::OUT_POLL: begin
					if (!rd_open) begin
						bus.arvalid <= 1'b1;
						bus.rready <= 1'b1;
						rd_open <= 1'b1;
					end else if (bus.rvalid) begin
						bus.rready <= 1'b0;
						rd_open <= 1'b0;
						if (bus.rresp == cpu_pkg::AXI_OKAY &&
								!bus.rdata[cpu_pkg::STAT_TX_FULL]) begin
							bus.awvalid <= 1'b1;
							bus.wvalid <= 1'b1;
							bus.bready <= 1'b1;
							state <= cpu_pkg::OUT_WRITE;
						end
					end
				end
				cpu_pkg::OUT_WRITE: if (bus.bvalid) begin
					bus.bready <= 1'b0;
					// Byte not taken on an error response
					state <= (bus.bresp == cpu_pkg::AXI_OKAY) ?
						cpu_pkg::FETCH : cpu_pkg::OUT_POLL;
				end
				default: state <= cpu_pkg::IDLE;
			endcase
		end
	end
endmodule

// File: source/cpu_top.sv
`timescale 1ns/10ps

module cpu_top (
	input logic clk,
	input logic rstn,
	input logic load_start,
	input logic run_start,
	output cpu_pkg::uart_addr_t uart_araddr,
	output logic uart_arvalid,
	input logic uart_arready,
	input cpu_pkg::data_t uart_rdata,
	input logic [1:0] uart_rresp,
	input logic uart_rvalid,
	output logic uart_rready,
	output cpu_pkg::uart_addr_t uart_awaddr,
	output logic uart_awvalid,
	input logic uart_awready,
	output cpu_pkg::data_t uart_wdata,
	output logic [3:0] uart_wstrb,
	output logic uart_wvalid,
	input logic uart_wready,
	input logic [1:0] uart_bresp,
	input logic uart_bvalid,
	output logic uart_bready
);
	logic imem_we;
	cpu_pkg::pc_t imem_waddr;
	cpu_pkg::data_t imem_wdata;
	cpu_pkg::pc_t imem_raddr;
	cpu_pkg::data_t imem_rdata;

	axil_if ld_bus ();
	axil_if core_bus ();
	axil_if uart_bus ();

	uart_arbiter i_arbiter (
		.clk(clk), .rstn(rstn),
		.ld_bus(ld_bus.slave), .core_bus(core_bus.slave), .uart_bus(uart_bus.master)
	);

	boot_loader i_loader (
		.clk(clk), .rstn(rstn), .load_start(load_start), .run_start(run_start),
		.bus(ld_bus.master),
		.imem_we(imem_we), .imem_waddr(imem_waddr), .imem_wdata(imem_wdata)
	);

	inst_ram i_ram (
		.clk(clk), .we(imem_we), .waddr(imem_waddr), .wdata(imem_wdata),
		.raddr(imem_raddr), .rdata(imem_rdata)
	);

	cpu_core i_core (
		.clk(clk), .rstn(rstn), .run_start(run_start),
		.imem_raddr(imem_raddr), .imem_rdata(imem_rdata), .bus(core_bus.master)
	);

	assign uart_araddr = uart_bus.araddr;
	assign uart_arvalid = uart_bus.arvalid;
	assign uart_bus.arready = uart_arready;
	assign uart_bus.rdata = uart_rdata;
	assign uart_bus.rresp = uart_rresp;
	assign uart_bus.rvalid = uart_rvalid;
	assign uart_rready = uart_bus.rready;
	assign uart_awaddr = uart_bus.awaddr;
	assign uart_awvalid = uart_bus.awvalid;
	assign uart_bus.awready = uart_awready;
	assign uart_wdata = uart_bus.wdata;
	assign uart_wstrb = uart_bus.wstrb;
	assign uart_wvalid = uart_bus.wvalid;
	assign uart_bus.wready = uart_wready;
	assign uart_bus.bresp = uart_bresp;
	assign uart_bus.bvalid = uart_bvalid;
	assign uart_bready = uart_bus.bready;
endmodule

// File: verification/uart_model.sv
`timescale 1ns/10ps

module uart_model (
	input logic clk,
	input logic rstn,
	input cpu_pkg::uart_addr_t uart_araddr,
	input logic uart_arvalid,
	output logic uart_arready,
	output cpu_pkg::data_t uart_rdata,
	output logic [1:0] uart_rresp,
	output logic uart_rvalid,
	input logic uart_rready,
	input cpu_pkg::uart_addr_t uart_awaddr,
	input logic uart_awvalid,
	output logic uart_awready,
	input cpu_pkg::data_t uart_wdata,
	input logic [3:0] uart_wstrb,
	input logic uart_wvalid,
	output logic uart_wready,
	output logic [1:0] uart_bresp,
	output logic uart_bvalid,
	input logic uart_bready,
	input logic rx_push,
	input logic [7:0] rx_byte,
	output int rx_left,
	output logic tx_valid,
	output logic [7:0] tx_byte
);
	logic [7:0] rx_q[$];
	cpu_pkg::uart_addr_t rd_addr;
	logic rd_pend; // Address taken, data not returned yet
	logic wr_pend;
	logic [7:0] wr_byte;
	logic [1:0] ar_dly;
	logic [1:0] r_dly;
	logic [1:0] w_dly;
	logic [1:0] b_dly;
	logic [1:0] full_polls; // TX-full replies left before the next byte

	assign rx_left = rx_q.size();
	assign uart_rresp = cpu_pkg::AXI_OKAY;
	assign uart_bresp = cpu_pkg::AXI_OKAY;

	function automatic logic [1:0] pick_delay();
		return 2'($urandom % 3);
	endfunction

	always @(posedge clk) begin
		tx_valid <= 1'b0;
		if (!rstn) begin
			rx_q.delete();
			uart_arready <= 1'b0;
			uart_rvalid <= 1'b0;
			uart_awready <= 1'b0;
			uart_wready <= 1'b0;
			uart_bvalid <= 1'b0;
			rd_pend <= 1'b0;
			wr_pend <= 1'b0;
			ar_dly <= pick_delay();
			w_dly <= pick_delay();
			full_polls <= 2'($urandom % 4);
		end else begin
			if (rx_push)
				rx_q.push_back(rx_byte);
			if (uart_arvalid && uart_arready) begin
				uart_arready <= 1'b0;
				rd_addr <= uart_araddr;
				rd_pend <= 1'b1;
				r_dly <= pick_delay();
			end else if (uart_arvalid && !rd_pend) begin
				if (ar_dly == 2'd0)
					uart_arready <= 1'b1;
				else
					ar_dly <= ar_dly - 2'd1;
			end
			if (rd_pend && !uart_rvalid) begin
				if (r_dly != 2'd0) begin
					r_dly <= r_dly - 2'd1;
				end else begin
					uart_rvalid <= 1'b1;
					uart_rdata <= '0;
					if (rd_addr == cpu_pkg::UART_RX_FIFO && rx_q.size() != 0)
						uart_rdata <= {24'd0, rx_q[0]};
					if (rd_addr == cpu_pkg::UART_STAT) begin
						uart_rdata[cpu_pkg::STAT_RX_VALID] <= (rx_q.size() != 0);
						uart_rdata[cpu_pkg::STAT_TX_FULL] <= (full_polls != 2'd0);
						if (full_polls != 2'd0)
							full_polls <= full_polls - 2'd1;
					end
				end
			end
			if (uart_rvalid && uart_rready) begin
				uart_rvalid <= 1'b0;
				rd_pend <= 1'b0;
				ar_dly <= pick_delay();
				if (rd_addr == cpu_pkg::UART_RX_FIFO && rx_q.size() != 0)
					rx_q.delete(0); // Byte consumed
			end
			// Address and data accepted together
			if (uart_awvalid && uart_awready) begin
				uart_awready <= 1'b0;
				uart_wready <= 1'b0;
				wr_byte <= uart_wdata[7:0];
				wr_pend <= 1'b1;
				b_dly <= pick_delay();
				full_polls <= 2'($urandom % 4);
			end else if (uart_awvalid && uart_wvalid && !wr_pend) begin
				if (w_dly == 2'd0) begin
					uart_awready <= 1'b1;
					uart_wready <= 1'b1;
				end else begin
					w_dly <= w_dly - 2'd1;
				end
			end
			if (wr_pend && !uart_bvalid) begin
				if (b_dly != 2'd0)
					b_dly <= b_dly - 2'd1;
				else
					uart_bvalid <= 1'b1;
			end
			if (uart_bvalid && uart_bready) begin
				uart_bvalid <= 1'b0;
				wr_pend <= 1'b0;
				w_dly <= pick_delay();
				tx_valid <= 1'b1; // Captured TX byte
				tx_byte <= wr_byte;
			end
		end
	end
endmodule

// File: verification/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb;
	logic clk = 1'b0;
	logic rstn;
	logic load_start;
	logic run_start;
	logic rx_push;
	logic [7:0] rx_byte;
	int rx_left;
	logic tx_valid;
	logic [7:0] tx_byte;
	cpu_pkg::uart_addr_t uart_araddr;
	logic uart_arvalid;
	logic uart_arready;
	cpu_pkg::data_t uart_rdata;
	logic [1:0] uart_rresp;
	logic uart_rvalid;
	logic uart_rready;
	cpu_pkg::uart_addr_t uart_awaddr;
	logic uart_awvalid;
	logic uart_awready;
	cpu_pkg::data_t uart_wdata;
	logic [3:0] uart_wstrb;
	logic uart_wvalid;
	logic uart_wready;
	logic [1:0] uart_bresp;
	logic uart_bvalid;
	logic uart_bready;

	cpu_pkg::data_t prog[$];
	logic [7:0] rx_stream[$];
	logic [7:0] exp_q[$];
	int n_seen = 0;
	int data_errs = 0;
	int bus_errs = 0;
	int timeouts = 0;
	logic pending = 1'b0; // Address accepted, response outstanding

	always #2 clk = ~clk;

	cpu_top i_cpu_top (.*);
	uart_model i_uart (.*);

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	function automatic void emit(cpu_pkg::op_group_e g, logic [2:0] s, int rt, int ra, int si);
		prog.push_back({g, s, 5'(rt), 5'(ra), 16'(si)});
	endfunction

	function automatic void out_word(int r);
		int k;
		for (k = 0; k < 4; k++)
			emit(cpu_pkg::GRP_IO, 3'(4 + k), r, 0, 0);
	endfunction

	function automatic void load_const(int r, cpu_pkg::data_t v);
		emit(cpu_pkg::GRP_MEM, cpu_pkg::SUB_LIS, r, 0, v[31:16]);
		emit(cpu_pkg::GRP_IMM, cpu_pkg::SUB_ADD, r, r, v[15:0]);
	endfunction

	function automatic void build_program();
		int r;
		int top;
		load_const(1, 32'hC0DE_1234);
		out_word(1);
		load_const(2, $urandom);
		load_const(3, $urandom | 32'h8000_0000); // Negative, for SRA sign fill
		emit(cpu_pkg::GRP_IMM, cpu_pkg::SUB_ADD, 4, 2, $urandom % 65536);
		emit(cpu_pkg::GRP_IMM, cpu_pkg::SUB_SUB, 5, 3, $urandom % 65536);
		emit(cpu_pkg::GRP_REG, cpu_pkg::SUB_ADD, 6, 2, 3 << 11);
		emit(cpu_pkg::GRP_REG, cpu_pkg::SUB_SUB, 7, 3, 2 << 11);
		emit(cpu_pkg::GRP_LOGIC, cpu_pkg::SUB_AND, 8, 2, 3 << 11);
		emit(cpu_pkg::GRP_LOGIC, cpu_pkg::SUB_OR, 9, 2, 3 << 11);
		emit(cpu_pkg::GRP_LOGIC, cpu_pkg::SUB_SRA, 10, 3, $urandom % 32);
		emit(cpu_pkg::GRP_LOGIC, cpu_pkg::SUB_SLA, 11, 2, $urandom % 32);
		for (r = 2; r <= 11; r++)
			out_word(r);
		emit(cpu_pkg::GRP_MEM, cpu_pkg::SUB_LI, 12, 0, 5); // Data base address
		emit(cpu_pkg::GRP_MEM, cpu_pkg::SUB_ST, 4, 12, 0);
		emit(cpu_pkg::GRP_MEM, cpu_pkg::SUB_ST, 6, 12, 3);
		emit(cpu_pkg::GRP_MEM, cpu_pkg::SUB_ST, 9, 12, 200);
		emit(cpu_pkg::GRP_MEM, cpu_pkg::SUB_LD, 13, 12, 200);
		emit(cpu_pkg::GRP_MEM, cpu_pkg::SUB_LD, 14, 12, 0);
		emit(cpu_pkg::GRP_MEM, cpu_pkg::SUB_LD, 15, 12, 3);
		for (r = 13; r <= 15; r++)
			out_word(r);
		emit(cpu_pkg::GRP_MEM, cpu_pkg::SUB_LI, 16, 0, 3); // Countdown
		emit(cpu_pkg::GRP_MEM, cpu_pkg::SUB_LI, 18, 0, 0);
		top = prog.size();
		emit(cpu_pkg::GRP_IO, 3'd4, 16, 0, 0);
		emit(cpu_pkg::GRP_IMM, cpu_pkg::SUB_SUB, 16, 16, 1);
		emit(cpu_pkg::GRP_BRANCH, cpu_pkg::SUB_CMP, 0, 18, 16 << 11);
		emit(cpu_pkg::GRP_BRANCH, cpu_pkg::SUB_BLT, 0, 0, top);
		emit(cpu_pkg::GRP_BRANCH, cpu_pkg::SUB_CMP, 0, 16, 18 << 11);
		emit(cpu_pkg::GRP_BRANCH, cpu_pkg::SUB_BEQ, 0, 0, prog.size() + 2);
		emit(cpu_pkg::GRP_IO, 3'd4, 1, 0, 0); // Skipped
		top = prog.size();
		emit(cpu_pkg::GRP_JUMP, cpu_pkg::SUB_J, 0, 0, top + 3);
		emit(cpu_pkg::GRP_IO, 3'd5, 2, 0, 0); // Subroutine body
		emit(cpu_pkg::GRP_JUMP, cpu_pkg::SUB_JR, cpu_pkg::LINK_REG, 0, 0);
		emit(cpu_pkg::GRP_JUMP, cpu_pkg::SUB_BL, 0, 0, top + 1);
		emit(cpu_pkg::GRP_IO, 3'd6, 3, 0, 0);
		emit(cpu_pkg::GRP_MEM, cpu_pkg::SUB_LI, 19, 0, 7);
		emit(cpu_pkg::GRP_MEM, cpu_pkg::SUB_LI, 20, 0, 7);
		emit(cpu_pkg::GRP_BRANCH, cpu_pkg::SUB_CMP, 0, 19, 20 << 11);
		emit(cpu_pkg::GRP_BRANCH, cpu_pkg::SUB_BLE, 0, 0, prog.size() + 2);
		emit(cpu_pkg::GRP_IO, 3'd4, 1, 0, 0); // Skipped
		emit(cpu_pkg::GRP_BRANCH, cpu_pkg::SUB_CMP, 0, 20, 18 << 11);
		emit(cpu_pkg::GRP_BRANCH, cpu_pkg::SUB_BLE, 0, 0, prog.size() + 2); // Not taken
		emit(cpu_pkg::GRP_IO, 3'd4, 19, 0, 0);
		emit(cpu_pkg::GRP_JUMP, cpu_pkg::SUB_J, 0, 0, prog.size()); // Halt loop
	endfunction

	// Instruction-set model of the loaded program
	function automatic void run_reference();
		cpu_pkg::data_t r[32];
		cpu_pkg::data_t dm[cpu_pkg::DMEM_DEPTH];
		cpu_pkg::data_t w;
		cpu_pkg::data_t x;
		cpu_pkg::data_t y;
		cpu_pkg::data_t si;
		cpu_pkg::reg_idx_t rt;
		cpu_pkg::reg_idx_t rb;
		cpu_pkg::pc_t pc;
		cpu_pkg::pc_t npc;
		logic [2:0] s;
		logic eq;
		logic lt;
		logic done;
		int steps;
		int i;
		int k;
		for (i = 0; i < prog.size(); i++)
			for (k = 0; k < 4; k++)
				rx_stream.push_back(prog[i][8 * k +: 8]); // Little-endian
		pc = '0;
		eq = 1'b0;
		lt = 1'b0;
		done = 1'b0;
		for (steps = 0; !done && steps < 5000; steps++) begin
			w = prog[pc];
			s = w[28:26];
			rt = w[25:21];
			rb = w[15:11];
			x = r[w[20:16]];
			si = {16'd0, w[15:0]};
			npc = pc + 10'd1;
			case (cpu_pkg::op_group_e'(w[31:29]))
				cpu_pkg::GRP_IMM, cpu_pkg::GRP_REG: begin
					y = (w[31:29] == cpu_pkg::GRP_IMM) ? si : r[rb];
					if (s == cpu_pkg::SUB_ADD)
						r[rt] = x + y;
					else if (s == cpu_pkg::SUB_SUB)
						r[rt] = x - y;
				end
				cpu_pkg::GRP_LOGIC: case (s)
					cpu_pkg::SUB_AND: r[rt] = x & r[rb];
					cpu_pkg::SUB_OR: r[rt] = x | r[rb];
					cpu_pkg::SUB_SRA: r[rt] = $signed(x) >>> si[4:0];
					cpu_pkg::SUB_SLA: r[rt] = x << si[4:0];
					default: ;
				endcase
				cpu_pkg::GRP_MEM: case (s)
					cpu_pkg::SUB_LD: r[rt] = dm[8'(x + si)];
					cpu_pkg::SUB_ST: dm[8'(x + si)] = r[rt];
					cpu_pkg::SUB_LI: r[rt] = si;
					cpu_pkg::SUB_LIS: r[rt] = {w[15:0], 16'd0};
					default: ;
				endcase
				cpu_pkg::GRP_JUMP: begin
					y = r[rt]; // Target taken before the link write
					if (s == cpu_pkg::SUB_BL || s == cpu_pkg::SUB_BLR)
						r[cpu_pkg::LINK_REG] = {22'd0, npc};
					if (s == cpu_pkg::SUB_J || s == cpu_pkg::SUB_BL)
						npc = w[9:0];
					else if (s == cpu_pkg::SUB_JR || s == cpu_pkg::SUB_BLR)
						npc = y[9:0];
				end
				cpu_pkg::GRP_BRANCH: case (s)
					cpu_pkg::SUB_BEQ: if (eq) npc = w[9:0];
					cpu_pkg::SUB_BLE: if (eq || lt) npc = w[9:0];
					cpu_pkg::SUB_BLT: if (lt) npc = w[9:0];
					cpu_pkg::SUB_CMP: begin
						eq = (x == r[rb]);
						lt = ($signed(x) < $signed(r[rb]));
					end
					default: ;
				endcase
				cpu_pkg::GRP_IO: if (s[2]) exp_q.push_back(r[rt][8 * s[1:0] +: 8]);
				default: ;
			endcase
			done = (npc == pc);
			pc = npc;
		end
	endfunction

	always @(negedge clk) begin
		if (tx_valid) begin
			assert (n_seen < exp_q.size()) else begin
				data_errs++;
				$display("Extra TX byte %h after all %0d expected bytes", tx_byte, exp_q.size());
			end
			if (n_seen < exp_q.size())
				assert (tx_byte == exp_q[n_seen]) else begin
					data_errs++;
					$display("Mismatch at %0t: TX byte %0d expected %h seen %h",
						$time, n_seen, exp_q[n_seen], tx_byte);
				end
			n_seen++;
		end
	end

	// Bus rules at the top-level ports
	always @(negedge clk) begin
		if (uart_arvalid && uart_arready)
			assert (uart_araddr == cpu_pkg::UART_STAT || uart_araddr == cpu_pkg::UART_RX_FIFO)
			else begin
				bus_errs++;
				$display("Mismatch at %0t: read from UART offset %h", $time, uart_araddr);
			end
		if (uart_awvalid && uart_awready)
			assert (uart_awaddr == cpu_pkg::UART_TX_FIFO && uart_wstrb == 4'b0001 &&
					uart_wvalid && uart_wdata[31:8] == 24'd0) else begin
				bus_errs++;
				$display("Mismatch at %0t: write to offset %h strobe %b wvalid %b data %h",
					$time, uart_awaddr, uart_wstrb, uart_wvalid, uart_wdata);
			end
		if ((uart_arvalid && uart_arready) || (uart_awvalid && uart_awready)) begin
			assert (!pending) else begin
				bus_errs++;
				$display("A UART transaction started before the previous response at %0t", $time);
			end
			pending = 1'b1;
		end
		if ((uart_rvalid && uart_rready) || (uart_bvalid && uart_bready))
			pending = 1'b0;
	end

	initial begin
		int t;
		void'($urandom(32'h7700));
		rstn = 1'b0;
		load_start = 1'b0;
		run_start = 1'b0;
		rx_push = 1'b0;
		rx_byte = '0;
		build_program();
		run_reference();
		repeat (5) @(posedge clk);
		#1;
		rstn = 1'b1;
		foreach (rx_stream[i]) begin
			rx_push = 1'b1;
			rx_byte = rx_stream[i];
			next_cycle();
		end
		rx_push = 1'b0;
		load_start = 1'b1;
		next_cycle();
		load_start = 1'b0;
		for (t = 0; rx_left != 0 && t < 40000; t++)
			@(negedge clk);
		assert (rx_left == 0) else begin
			timeouts++;
			$display("Timeout: the boot loader did not read all program bytes");
		end
		// Next status poll comes after the last word write
		for (t = 0; t < 1000; t++) begin
			@(negedge clk);
			if (uart_arvalid && uart_arready && uart_araddr == cpu_pkg::UART_STAT)
				break;
		end
		assert (t < 1000) else begin
			timeouts++;
			$display("Timeout: the boot loader stopped polling the UART");
		end
		next_cycle();
		run_start = 1'b1;
		next_cycle();
		run_start = 1'b0;
		for (t = 0; n_seen < exp_q.size() && t < 100000; t++)
			@(negedge clk);
		assert (n_seen >= exp_q.size()) else begin
			timeouts++;
			$display("Timeout: only %0d of %0d TX bytes arrived", n_seen, exp_q.size());
		end
		repeat (300) @(negedge clk); // Program now spins in its halt loop
		assert (n_seen == exp_q.size()) else begin
			data_errs++;
			$display("Mismatch at %0t: TX byte count expected %0d seen %0d",
				$time, exp_q.size(), n_seen);
		end
		$display("Errors: %0d data, %0d bus, %0d timeout", data_errs, bus_errs, timeouts);
		if (data_errs + bus_errs + timeouts == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end
endmodule

// File: filelist.f
source/cpu_pkg.sv
source/axil_if.sv
source/cpu_alu.sv
source/inst_ram.sv
source/uart_arbiter.sv
source/boot_loader.sv
source/cpu_core.sv
source/cpu_top.sv
verification/uart_model.sv
verification/cpu_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS := --binary --timing --assert -Wno-fatal -j 0
TOP := cpu_tb
FILELIST := filelist.f
OBJ_DIR := obj_dir
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
